//--- logic/tcdm_pkg.sv
// TCDM master-side protocol package with widths, opcodes and request/response types
package tcdm_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int unsigned ADDR_WIDTH = 32;               // Byte address
    localparam int unsigned DATA_WIDTH = 32;               // One word
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;   // One enable per byte
    localparam int unsigned WORD_BITS  = $clog2(BE_WIDTH); // Byte offset inside a word

    // Request type, same polarity as the classic wen bit
    typedef enum logic {
        OP_STORE = 1'b0,
        OP_LOAD  = 1'b1
    } tcdm_op_e;

    ////////////////////////////////////////////////////////////
    // Payloads
    ////////////////////////////////////////////////////////////
    // Travels beside the req valid bit, 69 bits wide
    typedef struct packed {
        tcdm_op_e              op;     // Load or store
        logic [ADDR_WIDTH-1:0] addr;   // Byte address
        logic [DATA_WIDTH-1:0] wdata;  // Store data
        logic [BE_WIDTH-1:0]   be;     // Byte enables
    } tcdm_req_t;

    // One cycle after the grant edge
    typedef struct packed {
        logic                  r_valid;  // Response strobe
        logic [DATA_WIDTH-1:0] r_rdata;  // Load data, undefined for stores
    } tcdm_rsp_t;

endpackage

//--- logic/tcdm_bank_pkg.sv
// TCDM bank-side package with the row width and the bank request type
package tcdm_bank_pkg;

    import tcdm_pkg::*;

    ////////////////////////////////////////////////////////////
    // Bank geometry
    ////////////////////////////////////////////////////////////
    localparam int unsigned ROW_WIDTH = 6;  // 64 words per bank

    // What one SRAM bank sees each cycle
    typedef struct packed {
        logic                  en;     // Bank access this cycle
        tcdm_op_e              op;     // Load or store
        logic [ROW_WIDTH-1:0]  row;    // Word row inside the bank
        logic [DATA_WIDTH-1:0] wdata;  // Store data
        logic [BE_WIDTH-1:0]   be;     // Byte enables
    } bank_req_t;  // 44 bits

endpackage

//--- logic/tcdm_addr_decode.sv
// TCDM address decoder splitting crossbar addresses into word-interleaved bank and row
`timescale 1ns/1ps

module tcdm_addr_decode
    import tcdm_pkg::*, tcdm_bank_pkg::*;
#(
    parameter int unsigned  N_XBAR_MASTERS = 4,
    parameter int unsigned  N_XBAR_BANKS   = 4,
    localparam int unsigned BANK_BITS      = $clog2(N_XBAR_BANKS)
) (
    input  logic [N_XBAR_MASTERS-1:0][ADDR_WIDTH-1:0] addr_i,  // Byte address per master
    output logic [N_XBAR_MASTERS-1:0][BANK_BITS-1:0]  bank_o,  // Target bank
    output logic [N_XBAR_MASTERS-1:0][ROW_WIDTH-1:0]  row_o    // Row inside that bank
);

    // Field positions in the byte address
    localparam int unsigned BANK_LSB = WORD_BITS;              // Just above the byte offset
    localparam int unsigned ROW_LSB  = WORD_BITS + BANK_BITS;  // Above the bank index

    ////////////////////////////////////////////////////////////
    // Interleaving rule
    ////////////////////////////////////////////////////////////
    // Consecutive words land in consecutive banks
    // Bits above the row field are dropped so addresses alias
    always_comb begin
        for (int m = 0; m < N_XBAR_MASTERS; m++) begin
            bank_o[m] = addr_i[m][BANK_LSB +: BANK_BITS];
            row_o[m]  = addr_i[m][ROW_LSB +: ROW_WIDTH];
        end
    end

endmodule

//--- logic/tcdm_bank_arbiter.sv
// TCDM bank arbiter with per-bank round-robin grant and winner record
`timescale 1ns/1ps

module tcdm_bank_arbiter
    import tcdm_pkg::*, tcdm_bank_pkg::*;
#(
    parameter int unsigned  N_XBAR_MASTERS = 4,
    parameter int unsigned  N_XBAR_BANKS   = 4,
    localparam int unsigned BANK_BITS      = $clog2(N_XBAR_BANKS),
    localparam int unsigned MST_BITS       = $clog2(N_XBAR_MASTERS)
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic      [N_XBAR_MASTERS-1:0]            req_i,       // Request valid
    input  tcdm_req_t [N_XBAR_MASTERS-1:0]            req_data_i,  // Request payload
    input  logic      [N_XBAR_MASTERS-1:0][BANK_BITS-1:0] bank_i,  // From decoder
    input  logic      [N_XBAR_MASTERS-1:0][ROW_WIDTH-1:0] row_i,   // From decoder
    output logic      [N_XBAR_MASTERS-1:0]            gnt_o,       // Same-cycle grant
    output bank_req_t [N_XBAR_BANKS-1:0]              bank_req_o,  // One access per bank
    output logic      [N_XBAR_BANKS-1:0]              win_valid_o, // Bank granted someone
    output logic      [N_XBAR_BANKS-1:0][MST_BITS-1:0] win_idx_o   // Who won
);

    logic [N_XBAR_BANKS-1:0][N_XBAR_MASTERS-1:0] bank_hit;   // Master m wants bank b
    logic [N_XBAR_BANKS-1:0]                     win_valid;
    logic [N_XBAR_BANKS-1:0][MST_BITS-1:0]       win_idx;
    logic [N_XBAR_BANKS-1:0][MST_BITS-1:0]       rr_ptr_q;   // Search start per bank

    ////////////////////////////////////////////////////////////
    // Request matrix
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int b = 0; b < N_XBAR_BANKS; b++) begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                bank_hit[b][m] = req_i[m] && (bank_i[m] == BANK_BITS'(b));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////////////////////////
    always_comb begin
        int cand;
        win_valid = '0;
        win_idx   = '0;
        cand      = 0;
        for (int b = 0; b < N_XBAR_BANKS; b++) begin
            // Walk masters starting at the pointer, first hit wins
            for (int k = 0; k < N_XBAR_MASTERS; k++) begin
                cand = (int'(rr_ptr_q[b]) + k) % N_XBAR_MASTERS;
                if (!win_valid[b] && bank_hit[b][cand]) begin
                    win_valid[b] = 1'b1;
                    win_idx[b]   = MST_BITS'(cand);
                end
            end
        end
    end

    // Grants and bank-side requests
    always_comb begin
        gnt_o = '0;
        for (int b = 0; b < N_XBAR_BANKS; b++) begin
            if (win_valid[b]) begin
                gnt_o[win_idx[b]] = 1'b1;  // A master targets one bank only
            end
            bank_req_o[b].en    = win_valid[b];
            bank_req_o[b].op    = req_data_i[win_idx[b]].op;
            bank_req_o[b].row   = row_i[win_idx[b]];
            bank_req_o[b].wdata = req_data_i[win_idx[b]].wdata;
            bank_req_o[b].be    = req_data_i[win_idx[b]].be;
        end
    end

    assign win_valid_o = win_valid;  // To response router
    assign win_idx_o   = win_idx;

    ////////////////////////////////////////////////////////////
    // Pointer update at the grant edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr_q <= '0;
        end else begin
            for (int b = 0; b < N_XBAR_BANKS; b++) begin
                if (win_valid[b]) begin
                    // Move just past the winner, wrap at the last master
                    rr_ptr_q[b] <= (win_idx[b] == MST_BITS'(N_XBAR_MASTERS - 1)) ?
                                   '0 : win_idx[b] + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/tcdm_rsp_router.sv
// TCDM response router steering registered bank read data back to the winning masters
`timescale 1ns/1ps

module tcdm_rsp_router
    import tcdm_pkg::*;
#(
    parameter int unsigned  N_XBAR_MASTERS = 4,
    parameter int unsigned  N_XBAR_BANKS   = 4,
    localparam int unsigned MST_BITS       = $clog2(N_XBAR_MASTERS)
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic      [N_XBAR_BANKS-1:0]               win_valid_i,   // Granted this cycle
    input  logic      [N_XBAR_BANKS-1:0][MST_BITS-1:0] win_idx_i,     // Winner per bank
    input  logic      [N_XBAR_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata_i, // Registered in bank
    output tcdm_rsp_t [N_XBAR_MASTERS-1:0]             rsp_o
);

    logic [N_XBAR_BANKS-1:0]               win_valid_q;  // Access done last cycle
    logic [N_XBAR_BANKS-1:0][MST_BITS-1:0] win_idx_q;

    ////////////////////////////////////////////////////////////
    // Winner record, one cycle behind the grant
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid_q <= '0;
        end else begin
            win_valid_q <= win_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        win_idx_q <= win_idx_i;  // Only read when valid is set
    end

    ////////////////////////////////////////////////////////////
    // Steering
    ////////////////////////////////////////////////////////////
    always_comb begin
        rsp_o = '0;
        for (int b = 0; b < N_XBAR_BANKS; b++) begin
            if (win_valid_q[b]) begin
                // Each master won at most one bank, no collisions here
                rsp_o[win_idx_q[b]].r_valid = 1'b1;
                rsp_o[win_idx_q[b]].r_rdata = bank_rdata_i[b];
            end
        end
    end

endmodule

//--- logic/tcdm_p2p_port.sv
// TCDM point-to-point channel with constant grant and one-cycle response valid
`timescale 1ns/1ps

module tcdm_p2p_port
    import tcdm_pkg::*, tcdm_bank_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_i,         // Request valid
    input  tcdm_req_t             req_data_i,    // Request payload
    output logic                  gnt_o,         // Never stalls
    output bank_req_t             bank_req_o,    // Private bank access
    input  logic [DATA_WIDTH-1:0] bank_rdata_i,  // Private bank read data
    output tcdm_rsp_t             rsp_o
);

    logic req_q;  // Request seen last cycle

    assign gnt_o = 1'b1;  // Owns its bank

    // Word row straight from the address, no bank field
    assign bank_req_o.en    = req_i;
    assign bank_req_o.op    = req_data_i.op;
    assign bank_req_o.row   = req_data_i.addr[WORD_BITS +: ROW_WIDTH];
    assign bank_req_o.wdata = req_data_i.wdata;
    assign bank_req_o.be    = req_data_i.be;

    ////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_i;
        end
    end

    assign rsp_o.r_valid = req_q;
    assign rsp_o.r_rdata = bank_rdata_i;  // Bank already registered it

endmodule

//--- logic/tcdm_sram_bank.sv
// TCDM SRAM bank model with byte-enabled writes and registered reads
`timescale 1ns/1ps

module tcdm_sram_bank
    import tcdm_pkg::*, tcdm_bank_pkg::*;
(
    input  logic                  clk,
    input  bank_req_t             bank_req_i,  // One access per cycle
    output logic [DATA_WIDTH-1:0] rdata_o      // Valid the cycle after a load
);

    localparam int unsigned N_ROWS = 2 ** ROW_WIDTH;

    logic [DATA_WIDTH-1:0] mem_q [N_ROWS];  // Storage array
    logic [DATA_WIDTH-1:0] rdata_q;

    ////////////////////////////////////////////////////////////
    // Single port access
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (bank_req_i.en) begin
            if (bank_req_i.op == OP_STORE) begin
                // Only enabled bytes change
                for (int i = 0; i < BE_WIDTH; i++) begin
                    if (bank_req_i.be[i]) begin
                        mem_q[bank_req_i.row][i*8 +: 8] <= bank_req_i.wdata[i*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[bank_req_i.row];  // Old contents
            end
        end
    end

    // Holds last load result between accesses
    assign rdata_o = rdata_q;

endmodule

//--- logic/tcdm_subsystem.sv
// TCDM subsystem top with interleaved crossbar banks and private point-to-point banks
`timescale 1ns/1ps

module tcdm_subsystem
    import tcdm_pkg::*, tcdm_bank_pkg::*;
#(
    parameter int unsigned  N_XBAR_MASTERS = 4,
    parameter int unsigned  N_XBAR_BANKS   = 4,
    parameter int unsigned  N_P2P          = 2,
    localparam int unsigned BANK_BITS      = $clog2(N_XBAR_BANKS),
    localparam int unsigned MST_BITS       = $clog2(N_XBAR_MASTERS)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // Crossbar masters
    input  logic      [N_XBAR_MASTERS-1:0]   xbar_req_i,
    input  tcdm_req_t [N_XBAR_MASTERS-1:0]   xbar_req_data_i,
    output logic      [N_XBAR_MASTERS-1:0]   xbar_gnt_o,
    output tcdm_rsp_t [N_XBAR_MASTERS-1:0]   xbar_rsp_o,
    // Point-to-point masters
    input  logic      [N_P2P-1:0]            p2p_req_i,
    input  tcdm_req_t [N_P2P-1:0]            p2p_req_data_i,
    output logic      [N_P2P-1:0]            p2p_gnt_o,
    output tcdm_rsp_t [N_P2P-1:0]            p2p_rsp_o
);

    logic      [N_XBAR_MASTERS-1:0][ADDR_WIDTH-1:0] xbar_addr;
    logic      [N_XBAR_MASTERS-1:0][BANK_BITS-1:0]  xbar_bank;   // Decoded bank
    logic      [N_XBAR_MASTERS-1:0][ROW_WIDTH-1:0]  xbar_row;    // Decoded row
    bank_req_t [N_XBAR_BANKS-1:0]                   xbar_bank_req;
    logic      [N_XBAR_BANKS-1:0][DATA_WIDTH-1:0]   xbar_bank_rdata;
    logic      [N_XBAR_BANKS-1:0]                   win_valid;
    logic      [N_XBAR_BANKS-1:0][MST_BITS-1:0]     win_idx;
    bank_req_t [N_P2P-1:0]                          p2p_bank_req;
    logic      [N_P2P-1:0][DATA_WIDTH-1:0]          p2p_bank_rdata;

    ////////////////////////////////////////////////////////////
    // Crossbar path
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < N_XBAR_MASTERS; m++) begin : g_xbar_addr
        assign xbar_addr[m] = xbar_req_data_i[m].addr;
    end

    tcdm_addr_decode #(
        .N_XBAR_MASTERS (N_XBAR_MASTERS),
        .N_XBAR_BANKS   (N_XBAR_BANKS)
    ) u_addr_decode (
        .addr_i (xbar_addr),
        .bank_o (xbar_bank),
        .row_o  (xbar_row)
    );

    tcdm_bank_arbiter #(
        .N_XBAR_MASTERS (N_XBAR_MASTERS),
        .N_XBAR_BANKS   (N_XBAR_BANKS)
    ) u_bank_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (xbar_req_i),
        .req_data_i  (xbar_req_data_i),
        .bank_i      (xbar_bank),
        .row_i       (xbar_row),
        .gnt_o       (xbar_gnt_o),
        .bank_req_o  (xbar_bank_req),
        .win_valid_o (win_valid),
        .win_idx_o   (win_idx)
    );

    tcdm_rsp_router #(
        .N_XBAR_MASTERS (N_XBAR_MASTERS),
        .N_XBAR_BANKS   (N_XBAR_BANKS)
    ) u_rsp_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_valid_i  (win_valid),
        .win_idx_i    (win_idx),
        .bank_rdata_i (xbar_bank_rdata),
        .rsp_o        (xbar_rsp_o)
    );

    for (genvar b = 0; b < N_XBAR_BANKS; b++) begin : g_xbar_bank
        tcdm_sram_bank u_bank (
            .clk        (clk),
            .bank_req_i (xbar_bank_req[b]),
            .rdata_o    (xbar_bank_rdata[b])
        );
    end

    ////////////////////////////////////////////////////////////
    // Point-to-point path
    ////////////////////////////////////////////////////////////
    for (genvar p = 0; p < N_P2P; p++) begin : g_p2p
        tcdm_p2p_port u_port (
            .clk          (clk),
            .rst_n        (rst_n),
            .req_i        (p2p_req_i[p]),
            .req_data_i   (p2p_req_data_i[p]),
            .gnt_o        (p2p_gnt_o[p]),
            .bank_req_o   (p2p_bank_req[p]),
            .bank_rdata_i (p2p_bank_rdata[p]),
            .rsp_o        (p2p_rsp_o[p])
        );

        tcdm_sram_bank u_bank (  // Private, never shared
            .clk        (clk),
            .bank_req_i (p2p_bank_req[p]),
            .rdata_o    (p2p_bank_rdata[p])
        );
    end

endmodule

//--- sim/tb_tcdm_subsystem.sv
// TCDM subsystem testbench with LFSR stimulus, shadow memories and concurrent checks
`timescale 1ns/1ps

module tb_tcdm_subsystem
    import tcdm_pkg::*, tcdm_bank_pkg::*;
();

    localparam int unsigned N_XBAR_MASTERS = 4;
    localparam int unsigned N_XBAR_BANKS   = 4;
    localparam int unsigned N_P2P          = 2;
    localparam int unsigned BANK_BITS      = $clog2(N_XBAR_BANKS);
    localparam int unsigned XIDX_BITS      = BANK_BITS + ROW_WIDTH;           // Decoded words
    localparam int unsigned HIGH_BITS      = ADDR_WIDTH - XIDX_BITS - WORD_BITS; // Aliased part
    localparam int          TIMEOUT        = 20;                              // Cycles per wait

    logic                            clk;
    logic                            rst_n;
    logic                            rst_q;        // rst_n one edge later
    logic      [N_XBAR_MASTERS-1:0]  xbar_req;
    tcdm_req_t [N_XBAR_MASTERS-1:0]  xbar_data;
    logic      [N_XBAR_MASTERS-1:0]  xbar_gnt;
    tcdm_rsp_t [N_XBAR_MASTERS-1:0]  xbar_rsp;
    logic      [N_P2P-1:0]           p2p_req;
    tcdm_req_t [N_P2P-1:0]           p2p_data;
    logic      [N_P2P-1:0]           p2p_gnt;
    tcdm_rsp_t [N_P2P-1:0]           p2p_rsp;

    // Shadow state and expected responses
    logic [DATA_WIDTH-1:0] xbar_mem [2**XIDX_BITS];        // One word per decoded address
    logic [DATA_WIDTH-1:0] p2p_mem  [N_P2P][2**ROW_WIDTH]; // One word per private row
    logic [N_XBAR_MASTERS-1:0]                 xexp_valid, xexp_load;
    logic [N_XBAR_MASTERS-1:0][DATA_WIDTH-1:0] xexp_data;
    logic [N_P2P-1:0]                          pexp_valid, pexp_load;
    logic [N_P2P-1:0][DATA_WIDTH-1:0]          pexp_data;
    int                                        xwait [N_XBAR_MASTERS]; // Cycles held ungranted
    logic [N_XBAR_BANKS-1:0][N_XBAR_MASTERS-1:0] bank_hit;
    logic [N_XBAR_MASTERS-1:0]                 alone;       // Only requester of its bank
    logic [N_XBAR_MASTERS-1:0]                 xbar_rvalid;
    logic [N_P2P-1:0]                          p2p_rvalid;

    logic [31:0] lfsr;
    string       test_name;
    int          errors, test_start, tests_passed, tests_failed;

    tcdm_subsystem #(
        .N_XBAR_MASTERS (N_XBAR_MASTERS),
        .N_XBAR_BANKS   (N_XBAR_BANKS),
        .N_P2P          (N_P2P)
    ) DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .xbar_req_i      (xbar_req),
        .xbar_req_data_i (xbar_data),
        .xbar_gnt_o      (xbar_gnt),
        .xbar_rsp_o      (xbar_rsp),
        .p2p_req_i       (p2p_req),
        .p2p_req_data_i  (p2p_data),
        .p2p_gnt_o       (p2p_gnt),
        .p2p_rsp_o       (p2p_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic tcdm_req_t rand_req();
        tcdm_req_t r;
        r.op    = (rand_bits(1) != 0) ? OP_LOAD : OP_STORE;
        r.addr  = rand_bits(ADDR_WIDTH);
        r.wdata = rand_bits(DATA_WIDTH);
        r.be    = BE_WIDTH'(rand_bits(BE_WIDTH));
        return r;
    endfunction

    // Byte-enable write rule
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                          input logic [DATA_WIDTH-1:0] wdata,
                                                          input logic [BE_WIDTH-1:0]   be);
        logic [DATA_WIDTH-1:0] r;
        r = old_word;
        for (int i = 0; i < BE_WIDTH; i++) begin
            if (be[i]) r[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model sampled at the grant edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        int idx;
        rst_q <= rst_n;
        if (!rst_n) begin
            xexp_valid <= '0;
            pexp_valid <= '0;
            for (int m = 0; m < N_XBAR_MASTERS; m++) xwait[m] <= 0;
        end else begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                xwait[m] <= (xbar_req[m] && !xbar_gnt[m]) ? xwait[m] + 1 : 0;
                if (xbar_req[m] && xbar_gnt[m]) begin
                    idx = int'(xbar_data[m].addr[WORD_BITS +: XIDX_BITS]); // {row, bank}
                    xexp_load[m] <= (xbar_data[m].op == OP_LOAD);
                    xexp_data[m] <= xbar_mem[idx];  // Old word
                    if (xbar_data[m].op == OP_STORE)
                        xbar_mem[idx] = merge_bytes(xbar_mem[idx], xbar_data[m].wdata,
                                                    xbar_data[m].be);
                end
            end
            xexp_valid <= xbar_req & xbar_gnt;
            for (int p = 0; p < N_P2P; p++) begin
                if (p2p_req[p] && p2p_gnt[p]) begin
                    idx = int'(p2p_data[p].addr[WORD_BITS +: ROW_WIDTH]);
                    pexp_load[p] <= (p2p_data[p].op == OP_LOAD);
                    pexp_data[p] <= p2p_mem[p][idx];
                    if (p2p_data[p].op == OP_STORE)
                        p2p_mem[p][idx] = merge_bytes(p2p_mem[p][idx], p2p_data[p].wdata,
                                                      p2p_data[p].be);
                end
            end
            pexp_valid <= p2p_req & p2p_gnt;
        end
    end

    // Who targets which bank under the interleaving rule
    always_comb begin
        for (int b = 0; b < N_XBAR_BANKS; b++) begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                bank_hit[b][m] = xbar_req[m] &&
                    (xbar_data[m].addr[WORD_BITS +: BANK_BITS] == BANK_BITS'(b));
            end
        end
        for (int m = 0; m < N_XBAR_MASTERS; m++) begin
            alone[m] = xbar_req[m] &&
                ($countones(bank_hit[xbar_data[m].addr[WORD_BITS +: BANK_BITS]]) == 1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks at the falling edge where all signals have settled
    ////////////////////////////////////////////////////////////
    a_reset_quiet: assert property (@(negedge clk)
        (!rst_n || !rst_q) |-> (xbar_rvalid == '0 && p2p_rvalid == '0))
        else begin
            $display("Response valid seen in or right after reset");
            errors++;
        end

    for (genvar m = 0; m < N_XBAR_MASTERS; m++) begin : g_xbar_chk
        assign xbar_rvalid[m] = xbar_rsp[m].r_valid;

        a_rvalid: assert property (@(negedge clk) disable iff (!rst_n)
            xbar_rsp[m].r_valid == $past(xbar_req[m] && xbar_gnt[m]))
            else begin
                $display("Crossbar port %0d response valid not one cycle after grant in %s",
                         m, test_name);
                errors++;
            end
        a_rdata: assert property (@(negedge clk) disable iff (!rst_n)
            (xexp_valid[m] && xexp_load[m]) |-> (xbar_rsp[m].r_rdata === xexp_data[m]))
            else begin
                $display("[FAIL] %s xbar port %0d: expected %h, actual %h", test_name, m,
                         xexp_data[m], xbar_rsp[m].r_rdata);
                errors++;
            end
        a_free_bank: assert property (@(negedge clk) disable iff (!rst_n)
            alone[m] |-> xbar_gnt[m])
            else begin
                $display("Crossbar port %0d not granted on a free bank", m);
                errors++;
            end
        a_fair: assert property (@(negedge clk) disable iff (!rst_n)
            xwait[m] < int'(N_XBAR_MASTERS))  // Round-robin bound
            else begin
                $display("Crossbar port %0d starved past the bound", m);
                errors++;
            end
    end

    for (genvar b = 0; b < N_XBAR_BANKS; b++) begin : g_bank_chk
        a_one_grant: assert property (@(negedge clk) disable iff (!rst_n)
            $onehot0(xbar_gnt & bank_hit[b]))
            else begin
                $display("Bank %0d granted to more than one master", b);
                errors++;
            end
    end

    for (genvar p = 0; p < N_P2P; p++) begin : g_p2p_chk
        assign p2p_rvalid[p] = p2p_rsp[p].r_valid;

        a_gnt: assert property (@(negedge clk) disable iff (!rst_n) p2p_gnt[p])
            else begin
                $display("Point-to-point port %0d grant dropped", p);
                errors++;
            end
        a_rvalid: assert property (@(negedge clk) disable iff (!rst_n)
            p2p_rsp[p].r_valid == $past(p2p_req[p]))
            else begin
                $display("Point-to-point port %0d response valid not one cycle after request",
                         p);
                errors++;
            end
        a_rdata: assert property (@(negedge clk) disable iff (!rst_n)
            (pexp_valid[p] && pexp_load[p]) |-> (p2p_rsp[p].r_rdata === pexp_data[p]))
            else begin
                $display("[FAIL] %s p2p port %0d: expected %h, actual %h", test_name, p,
                         pexp_data[p], p2p_rsp[p].r_rdata);
                errors++;
            end
    end

    ////////////////////////////////////////////////////////////
    // Drivers entered and left just after a rising edge
    ////////////////////////////////////////////////////////////
    task automatic p2p_access(input int p, input tcdm_req_t r);
        int t;
        t           = 0;
        p2p_data[p] = r;
        p2p_req[p]  = 1'b1;
        @(negedge clk);
        while (!p2p_gnt[p] && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!p2p_gnt[p]) begin
            $display("Timed out waiting for grant on point-to-point port %0d", p);
            errors++;
        end
        @(posedge clk);
        #1;
        p2p_req[p] = 1'b0;
    endtask

    // Raise the masked requests and hold each until granted
    task automatic xbar_burst(input logic [N_XBAR_MASTERS-1:0] mask);
        logic [N_XBAR_MASTERS-1:0] pend;
        int                        t;
        t        = 0;
        xbar_req = mask;
        while (xbar_req != '0 && t < TIMEOUT) begin
            @(negedge clk);
            pend = xbar_req & ~xbar_gnt;
            @(posedge clk);
            #1;
            xbar_req = pend;
            t++;
        end
        if (xbar_req != '0) begin
            $display("Timed out waiting for crossbar grants in %s", test_name);
            errors++;
            xbar_req = '0;
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = errors;
    endtask

    task automatic finish_test();
        @(negedge clk);  // Last response checked here
        #1;
        if (errors == test_start) begin
            tests_passed++;
            $display("Test %-10s ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %-10s %0d errors", test_name, errors - test_start);
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [N_XBAR_MASTERS-1:0] pend;
        logic [N_XBAR_MASTERS-1:0] won;
        tcdm_req_t                 r;
        tcdm_req_t                 r2;
        lfsr         = 32'hde53_1b79;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        rst_q        = 1'b0;
        xbar_req     = '0;
        xbar_data    = '0;
        p2p_req      = '0;
        p2p_data     = '0;

        start_test("reset");
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        finish_test();  // Covers first cycle after release

        // Fill, partial stores, then loads on private banks
        start_test("p2p");
        for (int p = 0; p < N_P2P; p++) begin
            for (int row = 0; row < 2**ROW_WIDTH; row++) begin
                r    = rand_req();
                r.op = OP_STORE;
                r.be = '1;
                r.addr[WORD_BITS +: ROW_WIDTH] = ROW_WIDTH'(row);
                p2p_access(p, r);
            end
            for (int k = 0; k < 64; k++) begin
                r    = rand_req();
                r.op = (k < 32) ? OP_STORE : OP_LOAD;
                p2p_access(p, r);
            end
        end
        finish_test();

        // Full fill then every master on its own bank each cycle
        start_test("xbar");
        for (int row = 0; row < 2**ROW_WIDTH; row++) begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                r    = rand_req();
                r.op = OP_STORE;
                r.be = '1;
                r.addr[WORD_BITS +: XIDX_BITS] = {ROW_WIDTH'(row), BANK_BITS'(m)};
                xbar_data[m] = r;
            end
            xbar_burst('1);
        end
        for (int k = 0; k < 16; k++) begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                r = rand_req();
                r.addr[WORD_BITS +: BANK_BITS] = BANK_BITS'((m + k) % N_XBAR_BANKS);
                xbar_data[m] = r;
            end
            xbar_burst('1);
        end
        finish_test();

        // Everyone on one bank and each winner asks again at once
        start_test("conflict");
        for (int k = 0; k < 6; k++) begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                r = rand_req();
                r.addr[WORD_BITS +: BANK_BITS] = BANK_BITS'(k % N_XBAR_BANKS);
                xbar_data[m] = r;
            end
            xbar_req = '1;
            for (int c = 0; c < 3 * N_XBAR_MASTERS; c++) begin
                @(negedge clk);
                won = xbar_req & xbar_gnt;
                @(posedge clk);
                #1;
                for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                    if (won[m]) begin
                        r = rand_req();
                        r.addr[WORD_BITS +: BANK_BITS] = BANK_BITS'(k % N_XBAR_BANKS);
                        xbar_data[m] = r;
                    end
                end
            end
            xbar_burst(xbar_req);  // Drain
        end
        finish_test();

        // Private writes stay off the crossbar and high address bits alias
        start_test("alias");
        for (int k = 0; k < 8; k++) begin
            r = rand_req();
            r.op = OP_STORE;
            for (int p = 0; p < N_P2P; p++) p2p_access(p, r);
            r.op         = OP_LOAD;
            xbar_data[0] = r;
            xbar_burst(N_XBAR_MASTERS'(1));
            r.op         = OP_STORE;
            r.be         = '1;
            xbar_data[1] = r;
            xbar_burst(N_XBAR_MASTERS'(2));
            r2    = r;
            r2.op = OP_LOAD;
            r2.addr[ADDR_WIDTH-1 -: HIGH_BITS] = r.addr[ADDR_WIDTH-1 -: HIGH_BITS] ^
                (HIGH_BITS'(rand_bits(HIGH_BITS)) | HIGH_BITS'(1));
            xbar_data[1] = r2;
            xbar_burst(N_XBAR_MASTERS'(2));
        end
        finish_test();

        // Mixed stream where ungranted requests stay put
        start_test("random");
        for (int c = 0; c < 300; c++) begin
            for (int m = 0; m < N_XBAR_MASTERS; m++) begin
                if (!xbar_req[m] && rand_bits(1) != 0) begin
                    xbar_data[m] = rand_req();
                    xbar_req[m]  = 1'b1;
                end
            end
            for (int p = 0; p < N_P2P; p++) begin
                p2p_data[p] = rand_req();
                p2p_req[p]  = (rand_bits(1) != 0);
            end
            @(negedge clk);
            pend = xbar_req & ~xbar_gnt;
            @(posedge clk);
            #1;
            xbar_req = pend;
        end
        p2p_req = '0;
        xbar_burst(xbar_req);  // Drain
        finish_test();

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
logic/tcdm_pkg.sv
logic/tcdm_bank_pkg.sv
logic/tcdm_addr_decode.sv
logic/tcdm_bank_arbiter.sv
logic/tcdm_rsp_router.sv
logic/tcdm_p2p_port.sv
logic/tcdm_sram_bank.sv
logic/tcdm_subsystem.sv
sim/tb_tcdm_subsystem.sv

//--- Bender.yml
package:
  name: tcdm_subsystem

sources:
  # Packages first, then leaf blocks, then the top level
  - logic/tcdm_pkg.sv
  - logic/tcdm_bank_pkg.sv
  - logic/tcdm_addr_decode.sv
  - logic/tcdm_bank_arbiter.sv
  - logic/tcdm_rsp_router.sv
  - logic/tcdm_p2p_port.sv
  - logic/tcdm_sram_bank.sv
  - logic/tcdm_subsystem.sv
  - target: simulation
    files:
      - sim/tb_tcdm_subsystem.sv
